// ==== Bender.yml ====
package:
  name: tinker

export_include_dirs:
  - include

sources:
  - rtl/tinker_pkg.sv
  - rtl/tinker_alu.sv
  - rtl/tinker_control.sv
  - rtl/tinker_regfile.sv
  - rtl/tinker_memory.sv
  - rtl/tinker_core.sv
  - target: test
    files:
      - tests/tinker_clock_gen.sv
      - tests/tinker_tb.sv

// ==== flist.f ====
+incdir+include
rtl/tinker_pkg.sv
rtl/tinker_alu.sv
rtl/tinker_control.sv
rtl/tinker_regfile.sv
rtl/tinker_memory.sv
rtl/tinker_core.sv
tests/tinker_clock_gen.sv
tests/tinker_tb.sv

// ==== include/tinker_macros.svh ====
// Widths, opcodes and fixed addresses for the Tinker core, included by every design file
`ifndef TINKER_MACROS_SVH
`define TINKER_MACROS_SVH

// ------------------------------------------------------------------------
// Widths
// ------------------------------------------------------------------------
`define TINKER_XLEN   64  // Data path
`define TINKER_ILEN   32  // Instruction word
`define TINKER_AW     32  // Byte address
`define TINKER_REG_AW 5   // 32 registers
`define TINKER_LIT_W  12  // Literal field
`define TINKER_OPC_W  5   // Opcode field

// Fixed addresses and sizes
`define TINKER_RESET_PC  32'h0000_2000          // First fetch
`define TINKER_STACK_TOP 64'h0000_0000_0008_0000 // r31 after reset
`define TINKER_MEM_BYTES (512 * 1024)

// ------------------------------------------------------------------------
// Opcodes
// ------------------------------------------------------------------------
`define TINKER_OP_AND    5'h00
`define TINKER_OP_OR     5'h01
`define TINKER_OP_XOR    5'h02
`define TINKER_OP_NOT    5'h03
`define TINKER_OP_SHFTR  5'h04
`define TINKER_OP_SHFTRI 5'h05
`define TINKER_OP_SHFTL  5'h06
`define TINKER_OP_SHFTLI 5'h07
`define TINKER_OP_BR     5'h08  // PC = rd
`define TINKER_OP_BRR    5'h09  // PC += rd
`define TINKER_OP_BRRL   5'h0A  // PC += sext(L)
`define TINKER_OP_BRNZ   5'h0B  // PC = rd if rs != 0
`define TINKER_OP_HALT   5'h0F
`define TINKER_OP_LOAD   5'h10  // rd = mem[rs + sext(L)]
`define TINKER_OP_MOV    5'h11  // rd = rs
`define TINKER_OP_MOVL   5'h12  // rd[11:0] = L
`define TINKER_OP_STORE  5'h13  // mem[rd + sext(L)] = rs
`define TINKER_OP_ADD    5'h18
`define TINKER_OP_ADDI   5'h19
`define TINKER_OP_SUB    5'h1A
`define TINKER_OP_SUBI   5'h1B
`define TINKER_OP_MUL    5'h1C

`endif

// ==== rtl/tinker_alu.sv ====
// Integer, logic, shift and move result unit, instantiated by the control block
`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_alu (
    input  tinker_pkg::instr_t      instr,
    input  logic [`TINKER_XLEN-1:0] op_a,    // rd for literal forms, else rs
    input  logic [`TINKER_XLEN-1:0] op_b,    // rt
    output logic [`TINKER_XLEN-1:0] result
);

    logic [`TINKER_XLEN-1:0] lit_sext;
    logic [`TINKER_XLEN-1:0] lit_zext;

    assign lit_sext = {{(`TINKER_XLEN - `TINKER_LIT_W){instr.lit[`TINKER_LIT_W-1]}},
                       instr.lit};
    assign lit_zext = {{(`TINKER_XLEN - `TINKER_LIT_W){1'b0}}, instr.lit};

    always_comb begin
        case (instr.opcode)
            // Arithmetic
            `TINKER_OP_ADD:    result = op_a + op_b;
            `TINKER_OP_ADDI:   result = op_a + lit_sext;   // Signed literal
            `TINKER_OP_SUB:    result = op_a - op_b;
            `TINKER_OP_SUBI:   result = op_a - lit_zext;   // Unsigned literal
            `TINKER_OP_MUL:    result = op_a * op_b;       // Low 64 bits kept

            // Logic
            `TINKER_OP_AND:    result = op_a & op_b;
            `TINKER_OP_OR:     result = op_a | op_b;
            `TINKER_OP_XOR:    result = op_a ^ op_b;
            `TINKER_OP_NOT:    result = ~op_a;             // rt unused

            // Shifts, all logical
            `TINKER_OP_SHFTR:  result = op_a >> op_b;
            `TINKER_OP_SHFTRI: result = op_a >> instr.lit;
            `TINKER_OP_SHFTL:  result = op_a << op_b;
            `TINKER_OP_SHFTLI: result = op_a << instr.lit;

            // Moves
            `TINKER_OP_MOV:    result = op_a;
            `TINKER_OP_MOVL: begin
                result = op_a;                             // Upper bits of rd kept
                result[`TINKER_LIT_W-1:0] = instr.lit;
            end

            default:           result = '0;
        endcase
    end

endmodule

// ==== rtl/tinker_control.sv ====
// Decoder for the latched instruction, giving register reads, next PC, writeback and store
`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_control (
    input  tinker_pkg::instr_t          ir,
    input  logic [`TINKER_AW-1:0]       pc,
    input  logic [`TINKER_XLEN-1:0]     op_a,
    input  logic [`TINKER_XLEN-1:0]     op_b,
    input  logic [`TINKER_XLEN-1:0]     load_data,
    output logic [`TINKER_REG_AW-1:0]   rf_addr_a,
    output logic [`TINKER_REG_AW-1:0]   rf_addr_b,
    output logic [`TINKER_AW-1:0]       load_addr,
    output tinker_pkg::store_req_t      store,
    output tinker_pkg::wb_req_t         wb,
    output logic [`TINKER_AW-1:0]       next_pc
);

    logic [`TINKER_XLEN-1:0] alu_result;
    logic [`TINKER_XLEN-1:0] lit_sext;
    logic [`TINKER_XLEN-1:0] eff_addr;    // Register plus literal, loads and stores
    logic                    writes_rd;

    tinker_alu i_tinker_alu (
        .instr  (ir),
        .op_a   (op_a),
        .op_b   (op_b),
        .result (alu_result)
    );

    assign lit_sext = {{(`TINKER_XLEN - `TINKER_LIT_W){ir.lit[`TINKER_LIT_W-1]}}, ir.lit};
    assign eff_addr = op_a + lit_sext;

    // ------------------------------------------------------------------------
    // Register read ports
    // ------------------------------------------------------------------------
    always_comb begin
        rf_addr_a = ir.rs;   // Three-register default
        rf_addr_b = ir.rt;
        case (ir.opcode)
            `TINKER_OP_ADDI, `TINKER_OP_SUBI, `TINKER_OP_SHFTRI,
            `TINKER_OP_SHFTLI, `TINKER_OP_MOVL,
            `TINKER_OP_BR, `TINKER_OP_BRR:  rf_addr_a = ir.rd;
            `TINKER_OP_BRNZ:                rf_addr_b = ir.rd;  // Condition stays on A
            `TINKER_OP_STORE: begin
                rf_addr_a = ir.rd;   // Base
                rf_addr_b = ir.rs;   // Data
            end
            default: ;
        endcase
    end

    // Next PC
    always_comb begin
        next_pc = pc + 32'd4;
        case (ir.opcode)
            `TINKER_OP_BR:   next_pc = op_a[`TINKER_AW-1:0];
            `TINKER_OP_BRR:  next_pc = pc + op_a[`TINKER_AW-1:0];
            `TINKER_OP_BRRL: next_pc = pc + lit_sext[`TINKER_AW-1:0];
            `TINKER_OP_BRNZ: begin
                if (op_a != '0)
                    next_pc = op_b[`TINKER_AW-1:0];
            end
            default: ;
        endcase
    end

    // ------------------------------------------------------------------------
    // Writeback and store requests
    // ------------------------------------------------------------------------
    always_comb begin
        case (ir.opcode)
            `TINKER_OP_ADD, `TINKER_OP_ADDI, `TINKER_OP_SUB, `TINKER_OP_SUBI,
            `TINKER_OP_MUL, `TINKER_OP_AND, `TINKER_OP_OR, `TINKER_OP_XOR,
            `TINKER_OP_NOT, `TINKER_OP_SHFTR, `TINKER_OP_SHFTRI, `TINKER_OP_SHFTL,
            `TINKER_OP_SHFTLI, `TINKER_OP_MOV, `TINKER_OP_MOVL,
            `TINKER_OP_LOAD: writes_rd = 1'b1;
            default:         writes_rd = 1'b0;
        endcase
    end

    // r0 is never requested, which also covers the all-zero halt word
    assign wb.en    = writes_rd && (ir.rd != '0);
    assign wb.dst   = ir.rd;
    assign wb.value = (ir.opcode == `TINKER_OP_LOAD) ? load_data : alu_result;

    assign load_addr  = eff_addr[`TINKER_AW-1:0];
    assign store.we   = (ir.opcode == `TINKER_OP_STORE);  // Core gates to MEMORY
    assign store.addr = eff_addr[`TINKER_AW-1:0];
    assign store.data = op_b;

endmodule

// ==== rtl/tinker_core.sv ====
// Top of the multicycle Tinker core, run from reset and loaded or read back via the host port
`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_core (
    input  logic                    clk,
    input  logic                    reset,
    input  tinker_pkg::host_req_t   host_req,   // Only while reset or hlt
    output logic [`TINKER_XLEN-1:0] host_rdata,
    output logic                    hlt
);

    import tinker_pkg::*;

    state_t                    state;
    state_t                    state_next;
    instr_t                    ir;
    logic [`TINKER_AW-1:0]     pc;
    logic [`TINKER_AW-1:0]     next_pc;
    logic [`TINKER_ILEN-1:0]   fetch_word;
    logic [`TINKER_XLEN-1:0]   load_word;
    logic [`TINKER_AW-1:0]     load_addr;
    logic [`TINKER_REG_AW-1:0] rf_addr_a;
    logic [`TINKER_REG_AW-1:0] rf_addr_b;
    logic [`TINKER_XLEN-1:0]   op_a;
    logic [`TINKER_XLEN-1:0]   op_b;
    store_req_t                ctrl_store;
    store_req_t                mem_store;
    wb_req_t                   ctrl_wb;
    wb_req_t                   wb_q;        // Held through WRITEBACK
    logic                      halting;

    tinker_memory i_tinker_memory (
        .clk        (clk),
        .fetch_addr (pc),
        .load_addr  (load_addr),
        .store      (mem_store),
        .host       (host_req),
        .fetch_word (fetch_word),
        .load_word  (load_word),
        .host_rdata (host_rdata)
    );

    tinker_regfile i_tinker_regfile (
        .clk    (clk),
        .reset  (reset),
        .wr     (wb_q),
        .addr_a (rf_addr_a),
        .addr_b (rf_addr_b),
        .data_a (op_a),
        .data_b (op_b)
    );

    tinker_control i_tinker_control (
        .ir        (ir),
        .pc        (pc),
        .op_a      (op_a),
        .op_b      (op_b),
        .load_data (load_word),
        .rf_addr_a (rf_addr_a),
        .rf_addr_b (rf_addr_b),
        .load_addr (load_addr),
        .store     (ctrl_store),
        .wb        (ctrl_wb),
        .next_pc   (next_pc)
    );

    // ------------------------------------------------------------------------
    // Sequencer, PC and halt
    // ------------------------------------------------------------------------
    always_comb begin
        case (state)
            FETCH:   state_next = DECODE;
            DECODE:  state_next = EXECUTE;
            EXECUTE: state_next = MEMORY;
            MEMORY:  state_next = WRITEBACK;
            default: state_next = FETCH;     // WRITEBACK wraps
        endcase
    end

    assign halting = (state == WRITEBACK) &&
                     ((ir.opcode == `TINKER_OP_HALT) || (ir == '0));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
            pc    <= `TINKER_RESET_PC;
            ir    <= '0;
            wb_q  <= '0;
            hlt   <= 1'b0;
        end else begin
            if (halting) begin
                hlt <= 1'b1;                 // State and PC frozen
            end else begin
                state <= state_next;
                if (state == WRITEBACK)
                    pc <= next_pc;
            end
            if (state == DECODE)
                ir <= fetch_word;
            if (state == MEMORY)
                wb_q <= ctrl_wb;             // Load word valid here
            else
                wb_q.en <= 1'b0;
        end
    end

    // Store lands on the edge leaving MEMORY
    always_comb begin
        mem_store    = ctrl_store;
        mem_store.we = ctrl_store.we && (state == MEMORY);
    end

    // Halt holds the sequencer in WRITEBACK with the PC frozen
    a_hlt_sticky: assert property (
        @(posedge clk) disable iff (reset)
        hlt |=> hlt && (state == WRITEBACK) && $stable(pc)
    );

endmodule

// ==== rtl/tinker_memory.sv ====
// Unified big-endian byte memory with fetch, load, core store and host access ports
`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_memory (
    input  logic                     clk,
    input  logic [`TINKER_AW-1:0]    fetch_addr,
    input  logic [`TINKER_AW-1:0]    load_addr,
    input  tinker_pkg::store_req_t   store,
    input  tinker_pkg::host_req_t    host,
    output logic [`TINKER_ILEN-1:0]  fetch_word,
    output logic [`TINKER_XLEN-1:0]  load_word,
    output logic [`TINKER_XLEN-1:0]  host_rdata
);

    localparam int WORD_BYTES  = `TINKER_XLEN / 8;
    localparam int INSTR_BYTES = `TINKER_ILEN / 8;

    logic [7:0] mem [`TINKER_MEM_BYTES];   // Contents come from the host

    // ------------------------------------------------------------------------
    // Writes, most significant byte at the lowest address
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (store.we) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                mem[store.addr + i] <= store.data[`TINKER_XLEN-1-8*i -: 8];
            end
        end
        if (host.we) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                mem[host.addr + i] <= host.wdata[`TINKER_XLEN-1-8*i -: 8];
            end
        end
    end

    // Combinational reads
    always_comb begin
        for (int i = 0; i < INSTR_BYTES; i++) begin
            fetch_word[`TINKER_ILEN-1-8*i -: 8] = mem[fetch_addr + i];
        end
        for (int i = 0; i < WORD_BYTES; i++) begin
            load_word[`TINKER_XLEN-1-8*i -: 8]  = mem[load_addr + i];
            host_rdata[`TINKER_XLEN-1-8*i -: 8] = mem[host.addr + i];
        end
    end

    // Whole store word inside the array
    a_store_in_range: assert property (
        @(posedge clk) store.we |-> (store.addr + 32'd7 < `TINKER_MEM_BYTES)
    );

    // Host only runs while the core is in reset or halted
    a_host_core_excl: assert property (
        @(posedge clk) !(host.we && store.we)
    );

endmodule

// ==== rtl/tinker_pkg.sv ====
// Shared types of the Tinker core, imported by the core and named in module ports
`include "tinker_macros.svh"

package tinker_pkg;

    // Instruction word, all fields at fixed positions
    typedef struct packed {
        logic [`TINKER_OPC_W-1:0]  opcode;  // [31:27]
        logic [`TINKER_REG_AW-1:0] rd;      // [26:22]
        logic [`TINKER_REG_AW-1:0] rs;      // [21:17]
        logic [`TINKER_REG_AW-1:0] rt;      // [16:12]
        logic [`TINKER_LIT_W-1:0]  lit;     // [11:0]
    } instr_t;

    // Multicycle sequencer
    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } state_t;

    // Core store into memory, 8 bytes big-endian
    typedef struct packed {
        logic                   we;
        logic [`TINKER_AW-1:0]  addr;
        logic [`TINKER_XLEN-1:0] data;
    } store_req_t;

    // Register file write
    typedef struct packed {
        logic                      en;
        logic [`TINKER_REG_AW-1:0] dst;
        logic [`TINKER_XLEN-1:0]   value;
    } wb_req_t;

    // Host access for program load and result readback
    typedef struct packed {
        logic                    we;
        logic [`TINKER_AW-1:0]   addr;
        logic [`TINKER_XLEN-1:0] wdata;
    } host_req_t;

endpackage

// ==== rtl/tinker_regfile.sv ====
// 32 by 64 register file of the core, two combinational reads and one clocked write
`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_regfile (
    input  logic                      clk,
    input  logic                      reset,
    input  tinker_pkg::wb_req_t       wr,       // Registered writeback from the core
    input  logic [`TINKER_REG_AW-1:0] addr_a,
    input  logic [`TINKER_REG_AW-1:0] addr_b,
    output logic [`TINKER_XLEN-1:0]   data_a,
    output logic [`TINKER_XLEN-1:0]   data_b
);

    localparam int NUM_REGS = 2 ** `TINKER_REG_AW;

    logic [`TINKER_XLEN-1:0] regs [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS - 1; i++) begin
                regs[i] <= '0;
            end
            regs[NUM_REGS-1] <= `TINKER_STACK_TOP;   // Stack pointer
        end else if (wr.en && (wr.dst != '0)) begin
            regs[wr.dst] <= wr.value;
        end
    end

    assign data_a = regs[addr_a];   // r0 reads as zero, never written
    assign data_b = regs[addr_b];

    // Control never requests r0 and the core holds that through WRITEBACK
    a_no_r0_write: assert property (
        @(posedge clk) disable iff (reset) wr.en |-> (wr.dst != '0)
    );

endmodule

// ==== tests/tinker_clock_gen.sv ====
// Testbench clock and reset source, 8 ns clock with power-on reset plus a reset hold input
`timescale 1ns/1ps

module tinker_clock_gen (
    input  logic hold,     // Extra reset while the program is loaded
    output logic clk,
    output logic reset
);

    logic por;             // Power-on part, 8 cycles

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        por = 1'b1;
        repeat (8) @(posedge clk);
        #1 por = 1'b0;
    end

    assign reset = por || hold;

endmodule

// ==== tests/tinker_tb.sv ====
// Testbench of the Tinker core, loads each table program through the host port and checks results
`timescale 1ns/1ps
`include "tinker_macros.svh"

module tinker_tb;

    import tinker_pkg::*;

    localparam int          NUM_TESTS  = 8;
    localparam int          RUN_LIMIT  = 200;    // Cycles until hlt
    localparam int          FREEZE_CYC = 20;     // Extra cycles after hlt
    localparam logic [31:0] PROG_BASE  = `TINKER_RESET_PC;
    localparam logic [31:0] DATA_ADDR  = 32'h0000_0400;

    logic                    clk;
    logic                    reset;
    logic                    hold;
    host_req_t               host_req;
    logic [`TINKER_XLEN-1:0] host_rdata;
    logic                    hlt;

    // Test table
    string       names      [NUM_TESTS];
    logic [31:0] progs      [NUM_TESTS][8];
    logic [63:0] data_words [NUM_TESTS];
    logic [31:0] res_addrs  [NUM_TESTS];
    logic [63:0] expected   [NUM_TESTS];

    integer seed;
    int     pass_count;
    int     fail_count;

    tinker_clock_gen i_tinker_clock_gen (
        .hold  (hold),
        .clk   (clk),
        .reset (reset)
    );

    tinker_core i_tinker_core (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .host_rdata (host_rdata),
        .hlt        (hlt)
    );

    // Fields opcode, rd, rs, rt, lit from msb down
    function automatic logic [31:0] encode(input int op, input int rd, input int rs,
                                           input int rt, input int lit);
        return {5'(op), 5'(rd), 5'(rs), 5'(rt), 12'(lit)};
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;   // Inputs move just after the edge
    endtask

    task automatic host_write(input logic [31:0] addr, input logic [63:0] wdata);
        host_req.we    = 1'b1;
        host_req.addr  = addr;
        host_req.wdata = wdata;
        next_cycle();
        host_req.we    = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Programs and expected results
    // ------------------------------------------------------------------------
    task automatic build_table();
        for (int i = 0; i < NUM_TESTS; i++)
            data_words[i] = {$random(seed), $random(seed)};

        // r0 as a destination must be dropped, subi literal zero-extended
        names[0] = "arith";
        progs[0] = '{encode(`TINKER_OP_ADDI, 2, 0, 0, 100), encode(`TINKER_OP_ADDI, 3, 0, 0, 'hFF9),
                     encode(`TINKER_OP_ADD, 0, 2, 3, 0), encode(`TINKER_OP_MUL, 4, 2, 3, 0),
                     encode(`TINKER_OP_SUB, 4, 4, 0, 0), encode(`TINKER_OP_SUBI, 4, 0, 0, 'h800),
                     encode(`TINKER_OP_STORE, 0, 4, 0, 'h500), 32'h0};
        res_addrs[0] = 32'h500;
        expected[0]  = 64'd100 * (64'd0 - 64'd7) - 64'd0 - 64'd2048;

        names[1] = "logic";
        progs[1] = '{encode(`TINKER_OP_LOAD, 1, 0, 0, 'h400), encode(`TINKER_OP_ADDI, 2, 0, 0, 'h5A3),
                     encode(`TINKER_OP_AND, 3, 1, 2, 0), encode(`TINKER_OP_XOR, 4, 1, 3, 0),
                     encode(`TINKER_OP_NOT, 4, 4, 0, 0), encode(`TINKER_OP_OR, 4, 4, 2, 0),
                     encode(`TINKER_OP_STORE, 0, 4, 0, 'h508), 32'h0};
        res_addrs[1] = 32'h508;
        expected[1]  = ~(data_words[1] ^ (data_words[1] & 64'h5A3)) | 64'h5A3;

        names[2] = "shift";
        progs[2] = '{encode(`TINKER_OP_LOAD, 1, 0, 0, 'h400), encode(`TINKER_OP_ADDI, 2, 0, 0, 5),
                     encode(`TINKER_OP_SHFTR, 3, 1, 2, 0), encode(`TINKER_OP_SHFTLI, 3, 0, 0, 9),
                     encode(`TINKER_OP_SHFTL, 3, 3, 2, 0), encode(`TINKER_OP_SHFTRI, 3, 0, 0, 3),
                     encode(`TINKER_OP_STORE, 0, 3, 0, 'h510), 32'h0};
        res_addrs[2] = 32'h510;
        expected[2]  = (((data_words[2] >> 5) << 9) << 5) >> 3;

        // Halt opcode must stop the core before the clearing store
        names[3] = "move";   // Only the low 12 bits replaced
        progs[3] = '{encode(`TINKER_OP_LOAD, 1, 0, 0, 'h400), encode(`TINKER_OP_MOV, 2, 1, 0, 0),
                     encode(`TINKER_OP_MOVL, 2, 0, 0, 'hABC),
                     encode(`TINKER_OP_STORE, 0, 2, 0, 'h518), encode(`TINKER_OP_HALT, 0, 0, 0, 0),
                     encode(`TINKER_OP_STORE, 0, 0, 0, 'h518), 32'h0, 32'h0};
        res_addrs[3] = 32'h518;
        expected[3]  = {data_words[3][63:12], 12'hABC};

        names[4] = "ldst";   // Negative load offset, store to 0x528
        progs[4] = '{encode(`TINKER_OP_ADDI, 1, 0, 0, 'h410), encode(`TINKER_OP_LOAD, 2, 1, 0, 'hFF0),
                     encode(`TINKER_OP_STORE, 1, 2, 0, 'h118), 32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
        res_addrs[4] = 32'h528;
        expected[4]  = data_words[4];

        // r6 = 0x2018, first brnz falls through, second skips the 0x100
        names[5] = "brnz";
        progs[5] = '{encode(`TINKER_OP_ADDI, 6, 0, 0, 'h403), encode(`TINKER_OP_SHFTLI, 6, 0, 0, 3),
                     encode(`TINKER_OP_BRNZ, 6, 0, 0, 0), encode(`TINKER_OP_ADDI, 5, 0, 0, 1),
                     encode(`TINKER_OP_BRNZ, 6, 6, 0, 0), encode(`TINKER_OP_ADDI, 5, 0, 0, 'h100),
                     encode(`TINKER_OP_STORE, 0, 5, 0, 'h530), 32'h0};
        res_addrs[5] = 32'h530;
        expected[5]  = 64'd1;

        // br to 0x2010 then brr +8, each skipped addi would corrupt r6
        names[6] = "br_brr";
        progs[6] = '{encode(`TINKER_OP_ADDI, 6, 0, 0, 'h402), encode(`TINKER_OP_SHFTLI, 6, 0, 0, 3),
                     encode(`TINKER_OP_BR, 6, 0, 0, 0), encode(`TINKER_OP_ADDI, 6, 0, 0, 'h100),
                     encode(`TINKER_OP_BRRL, 0, 0, 0, 8), encode(`TINKER_OP_ADDI, 6, 0, 0, 'h200),
                     encode(`TINKER_OP_STORE, 0, 6, 0, 'h538), 32'h0};
        res_addrs[6] = 32'h538;
        expected[6]  = 64'h402 << 3;

        names[7] = "halt";   // Store after the zero word must never run
        progs[7] = '{encode(`TINKER_OP_LOAD, 1, 0, 0, 'h400), encode(`TINKER_OP_STORE, 0, 1, 0, 'h540),
                     32'h0, encode(`TINKER_OP_STORE, 0, 0, 0, 'h540),
                     32'h0, 32'h0, 32'h0, 32'h0};
        res_addrs[7] = 32'h540;
        expected[7]  = data_words[7];
    endtask

    // ------------------------------------------------------------------------
    // One table entry: load under reset, run to hlt, check the result word
    // ------------------------------------------------------------------------
    task automatic run_test(input int idx);
        int n;
        hold = 1'b1;
        next_cycle();
        for (int k = 0; k < 4; k++) begin   // Two instructions per host write
            host_write(PROG_BASE + 32'(8 * k), {progs[idx][2*k], progs[idx][2*k+1]});
        end
        host_write(DATA_ADDR, data_words[idx]);
        host_write(res_addrs[idx], 64'd0);   // Clear stale result
        host_req.addr = res_addrs[idx];
        hold = 1'b0;
        n = 0;
        while (!hlt && n < RUN_LIMIT) begin
            next_cycle();
            n++;
        end
        if (!hlt) begin
            $display("Test %s did not halt within %0d cycles", names[idx], RUN_LIMIT);
            fail_count++;
        end else begin
            for (int c = 0; c < FREEZE_CYC; c++)
                next_cycle();
            if (hlt !== 1'b1) begin
                $display("Test %s: hlt dropped after the core halted", names[idx]);
                fail_count++;
            end else if (host_rdata !== expected[idx]) begin
                $display("FAIL %s: host_rdata = 0x%016h, expected 0x%016h",
                         names[idx], host_rdata, expected[idx]);
                fail_count++;
            end else begin
                $display("PASS %s: host_rdata = 0x%016h", names[idx], host_rdata);
                pass_count++;
            end
        end
    endtask

    initial begin
        seed       = 24958;
        pass_count = 0;
        fail_count = 0;
        hold       = 1'b1;
        host_req   = '0;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++)
            run_test(t);
        $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
